//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := scMulTb
FILELIST := scMulTop.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/axiLiteRegs.sv
`timescale 1ns/1ps

module axiLiteRegs import scPkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  regAddrT           awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  busT               wdata,
    input  logic [STRB_W-1:0] wstrb,
    input  logic              wvalid,
    output logic              wready,
    output respT              bresp,
    output logic              bvalid,
    input  logic              bready,
    input  regAddrT           araddr,
    input  logic              arvalid,
    output logic              arready,
    output busT               rdata,
    output respT              rresp,
    output logic              rvalid,
    input  logic              rready,
    input  logic              busy,
    input  logic              done,
    input  countT             result,
    output dataT              opA,
    output dataT              opB,
    output logic              startPulse
);

    logic wrFire;
    logic rdFire;
    logic fullWord;
    logic startArm;             // start seen one cycle before the pulse
    busT  rdMux;

    // AW and W taken together, and only with no B pending
    assign wrFire  = awvalid & wvalid & ~bvalid;
    assign awready = wrFire;
    assign wready  = wrFire;
    assign fullWord = wstrb == STRB_FULL;   // partial writes dropped

    assign rdFire  = arvalid & ~rvalid;
    assign arready = rdFire;

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opA        <= '0;
            opB        <= '0;
            bvalid     <= 1'b0;
            startArm   <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            startArm   <= 1'b0;
            startPulse <= startArm & ~busy;     // start while busy is dropped
            if (wrFire) begin
                bvalid <= 1'b1;
                if (fullWord) begin
                    case (awaddr)
                        ADDR_CTRL: startArm <= wdata[0];
                        ADDR_OPA:  opA <= wdata[DATA_W-1:0];
                        ADDR_OPB:  opB <= wdata[DATA_W-1:0];
                        default: ;              // status and result are read-only
                    endcase
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read data select
    always_comb begin
        case (araddr)
            ADDR_STATUS: rdMux = busT'({done, busy});
            ADDR_OPA:    rdMux = busT'(opA);
            ADDR_OPB:    rdMux = busT'(opB);
            ADDR_RESULT: rdMux = busT'(result);
            default:     rdMux = '0;    // ctrl and unmapped read as zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rdFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // data held with rvalid until rready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rdFire) begin
            rdata <= rdMux;
        end
    end

endmodule

//--- hdl/scControl.sv
`timescale 1ns/1ps

module scControl import scPkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic startPulse,
    output logic clear,
    output logic streamEn,
    output logic busy,
    output logic done
);

    ctrlStateT state;
    ctrlStateT nextState;
    countT     runCnt;          // stream cycles elapsed in RUN
    logic      lastCycle;

    assign lastCycle = runCnt == countT'(RUN_LEN - 1);

    always_comb begin
        nextState = state;
        case (state)
            IDLE, DONE: begin
                if (startPulse) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                nextState = RUN;        // single clear cycle
            end
            RUN: begin
                if (lastCycle) begin
                    nextState = DONE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            runCnt <= '0;
        end else if (state == RUN) begin
            runCnt <= runCnt + 1'b1;
        end else begin
            runCnt <= '0;
        end
    end

    // decoded straight from the state
    assign clear    = state == CLEAR;
    assign streamEn = state == RUN;
    assign busy     = (state == CLEAR) || (state == RUN);
    assign done     = state == DONE;    // held until the next start

endmodule

//--- hdl/scMulTop.sv
`timescale 1ns/1ps

module scMulTop import scPkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  regAddrT           awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  busT               wdata,
    input  logic [STRB_W-1:0] wstrb,
    input  logic              wvalid,
    output logic              wready,
    output respT              bresp,
    output logic              bvalid,
    input  logic              bready,
    input  regAddrT           araddr,
    input  logic              arvalid,
    output logic              arready,
    output busT               rdata,
    output respT              rresp,
    output logic              rvalid,
    input  logic              rready
);

    logic  startPulse;
    logic  busy;
    logic  done;
    logic  clear;
    logic  streamEn;
    dataT  opA;
    dataT  opB;
    countT result;

    axiLiteRegs regs0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .opA        (opA),
        .opB        (opB),
        .startPulse (startPulse)
    );

    scControl ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .startPulse (startPulse),
        .clear      (clear),
        .streamEn   (streamEn),
        .busy       (busy),
        .done       (done)
    );

    unaryMul mul0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .streamEn (streamEn),
        .opA      (opA),
        .opB      (opB),
        .result   (result)
    );

endmodule

//--- hdl/scPkg.sv
package scPkg;

    localparam int DATA_W  = 8;        // operand and sobol sample width
    localparam int COUNT_W = 9;        // wide enough for a full count of 256
    localparam int IDX_W   = 3;        // selects one of DATA_W direction vectors
    localparam int ADDR_W  = 5;
    localparam int BUS_W   = 32;
    localparam int STRB_W  = BUS_W / 8;
    localparam int RUN_LEN = 256;      // one full sobol period

    typedef logic [DATA_W-1:0]  dataT;
    typedef logic [COUNT_W-1:0] countT;
    typedef logic [IDX_W-1:0]   idxT;
    typedef logic [ADDR_W-1:0]  regAddrT;
    typedef logic [BUS_W-1:0]   busT;
    typedef logic [1:0]         respT;

    // register map, byte addresses
    localparam regAddrT ADDR_CTRL   = 5'h00;   // bit 0 start
    localparam regAddrT ADDR_STATUS = 5'h04;   // bit 0 busy, bit 1 done
    localparam regAddrT ADDR_OPA    = 5'h08;
    localparam regAddrT ADDR_OPB    = 5'h0C;
    localparam regAddrT ADDR_RESULT = 5'h10;

    localparam respT RESP_OKAY = 2'b00;
    localparam logic [STRB_W-1:0] STRB_FULL = '1;

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        RUN,
        DONE
    } ctrlStateT;

endpackage

//--- hdl/sobolGen.sv
`timescale 1ns/1ps

module sobolGen import scPkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic enable,
    output dataT sobolSeq
);

    dataT cnt;                  // sample index
    dataT dirVec [DATA_W];
    idxT  vecIdx;
    logic zeroFound;

    // identity direction vectors, vector 0 is the msb
    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            dirVec[i] = dataT'(1) << (DATA_W - 1 - i);
        end
    end

    // least significant zero of the index picks the vector
    always_comb begin
        vecIdx    = '0;
        zeroFound = 1'b0;
        for (int i = 0; i < DATA_W; i++) begin
            if (!zeroFound && !cnt[i]) begin
                vecIdx    = idxT'(i);
                zeroFound = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (enable) begin
            cnt <= cnt + 1'b1;
        end
    end

    // gray-code style update, one vector per step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sobolSeq <= '0;
        end else if (clear) begin
            sobolSeq <= '0;
        end else if (enable) begin
            sobolSeq <= sobolSeq ^ dirVec[vecIdx];
        end
    end

endmodule

//--- hdl/unaryMul.sv
`timescale 1ns/1ps

module unaryMul import scPkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  streamEn,
    input  dataT  opA,
    input  dataT  opB,
    output countT result
);

    dataT seqA;
    dataT seqB;
    logic bitA;
    logic bitB;
    logic enB;
    logic prodBit;

    // unary stream for A, one new sample per stream cycle
    sobolGen sobolA (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .enable   (streamEn),
        .sobolSeq (seqA)
    );

    assign bitA = opA > seqA;

    // uMUL: B only steps when A emits a one
    assign enB = streamEn & bitA;

    sobolGen sobolB (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .enable   (enB),
        .sobolSeq (seqB)
    );

    assign bitB    = opB > seqB;
    assign prodBit = bitA & bitB;   // AND of the two streams

    /*
     * ones counter over the run; the last product bit lands
     * on the edge that ends the final RUN cycle
     */
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (clear) begin
            result <= '0;
        end else if (streamEn) begin
            result <= result + countT'(prodBit);
        end
    end

endmodule

//--- scMulTop.f
hdl/scPkg.sv
hdl/sobolGen.sv
hdl/unaryMul.sv
hdl/scControl.sv
hdl/axiLiteRegs.sv
hdl/scMulTop.sv
verification/scMulTop_assert.sv
verification/scMulTb.sv

//--- verification/scMulTb.sv
`timescale 1ns/1ps

module scMulTb import scPkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int NUM_TESTS   = 10;
    localparam int NUM_CORNERS = 6;
    localparam int START_LAT   = 1;                // B response to startPulse
    localparam int DONE_LAT    = RUN_LEN + 2;      // startPulse and CLEAR before RUN
    localparam int WATCHDOG_NS = (NUM_TESTS * 300 + 2000) * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    regAddrT           awaddr;
    logic              awvalid;
    logic              awready;
    busT               wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    respT              bresp;
    logic              bvalid;
    logic              bready;
    regAddrT           araddr;
    logic              arvalid;
    logic              arready;
    busT               rdata;
    respT              rresp;
    logic              rvalid;
    logic              rready;

    // corner pairs first and random pairs filled in later
    dataT  tblA [NUM_TESTS] = '{8'd0, 8'd255, 8'd0, 8'd200, 8'd128, 8'd1, 0, 0, 0, 0};
    dataT  tblB [NUM_TESTS] = '{8'd0, 8'd255, 8'd200, 8'd0, 8'd128, 8'd255, 0, 0, 0, 0};
    countT tblExp [NUM_TESTS];
    int    seed       = 17033;
    int    errCount   = 0;
    int    checkCount = 0;
    int    cycle      = 0;
    int    doneRise   = -1;     // cycle of the latest done rising edge
    logic  donePrev   = 1'b0;

    scMulTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle    <= cycle + 1;
        donePrev <= dut0.done;
        if (dut0.done && !donePrev) begin
            doneRise <= cycle;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    // sample k is the bit-reversed gray code of k
    function automatic dataT sobolSample(input int k);
        dataT g;
        dataT r;
        g = dataT'(k ^ (k >> 1));
        for (int i = 0; i < DATA_W; i++) begin
            r[i] = g[DATA_W-1-i];
        end
        return r;
    endfunction

    // A emits opA ones so B sees samples 0 .. opA-1 in order
    function automatic countT expectCount(input dataT a, input dataT b);
        countT n;
        n = '0;
        for (int k = 0; k < int'(a); k++) begin
            if (b > sobolSample(k)) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    task automatic checkValue(input busT got, input busT exp, input string what);
        checkCount++;
        assert (got == exp) else begin
            errCount++;
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // called and returns just after a drive point
    task automatic axiWrite(input regAddrT addr, input busT data, output int bCyc);
        awaddr  = addr;
        wdata   = data;
        wstrb   = STRB_FULL;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(posedge clk);
        while (!(awready && wready)) begin
            @(posedge clk);
        end
        #(DRIVE_DLY);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(posedge clk);
        while (!bvalid) begin
            @(posedge clk);
        end
        bCyc = cycle;               // edge that raised bvalid
        checkValue(busT'(bresp), busT'(RESP_OKAY), "bresp");
        #(DRIVE_DLY);
        bready = 1'b0;
    endtask

    task automatic axiRead(input regAddrT addr, input int stall, output busT data);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        @(posedge clk);
        while (!arready) begin
            @(posedge clk);
        end
        #(DRIVE_DLY);
        arvalid = 1'b0;
        repeat (stall) begin        // R channel held off
            @(posedge clk);
            #(DRIVE_DLY);
        end
        rready = 1'b1;
        @(posedge clk);
        while (!rvalid) begin
            @(posedge clk);
        end
        data = rdata;
        checkValue(busT'(rresp), busT'(RESP_OKAY), "rresp");
        #(DRIVE_DLY);
        rready = 1'b0;
    endtask

    task automatic readExpect(input regAddrT addr, input int stall, input busT exp,
                              input string what);
        busT got;
        axiRead(addr, stall, got);
        checkValue(got, exp, what);
    endtask

    task automatic runEntry(input int idx);
        busT status;
        int  bCyc;
        int  unused;
        int  polls;
        axiWrite(ADDR_OPA, {24'hC3A500, tblA[idx]}, unused);    // upper bytes dropped
        axiWrite(ADDR_OPB, {24'h3CA5FF, tblB[idx]}, unused);
        readExpect(ADDR_OPA, 0, busT'(tblA[idx]), "OPA");
        readExpect(ADDR_OPB, 0, busT'(tblB[idx]), "OPB");
        axiWrite(ADDR_CTRL, 32'h1, bCyc);
        @(posedge clk);             // let startPulse reach the FSM
        #(DRIVE_DLY);
        readExpect(ADDR_STATUS, 0, 32'h1, "STATUS after start");
        if (idx % 2 == 1) begin
            axiWrite(ADDR_CTRL, 32'h1, unused);     // start while busy
        end
        polls  = 0;
        status = '0;
        while (!status[1] && polls < 100) begin
            repeat (4) @(posedge clk);
            #(DRIVE_DLY);
            axiRead(ADDR_STATUS, 0, status);
            polls++;
        end
        checkCount++;
        assert (status[1]) else begin
            errCount++;
            $display("Run %0d never reported done in the STATUS register", idx);
        end
        checkCount++;
        assert (doneRise - bCyc == START_LAT + DONE_LAT) else begin
            errCount++;
            $display("Error at %0d ns: done rose %0d cycles after the B response, expected %0d",
                     $time, doneRise - bCyc, START_LAT + DONE_LAT);
        end
        readExpect(ADDR_STATUS, 0, 32'h2, "STATUS when done");
        readExpect(ADDR_RESULT, 2 + idx % 3, busT'(tblExp[idx]), "RESULT");
    endtask

    initial begin
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = NUM_CORNERS; i < NUM_TESTS; i++) begin
            tblA[i] = dataT'($random(seed));
            tblB[i] = dataT'($random(seed));
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            tblExp[i] = expectCount(tblA[i], tblB[i]);
        end
        repeat (2) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        readExpect(5'h14, 0, 32'h0, "unmapped 0x14");
        readExpect(5'h1C, 3, 32'h0, "unmapped 0x1C");
        // back to back runs with no reset in between
        for (int i = 0; i < NUM_TESTS; i++) begin
            runEntry(i);
        end
        $display("checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verification/scMulTop_assert.sv
`timescale 1ns/1ps

module scMulTop_assert import scPkg::*; (
    input logic    clk,
    input logic    rst_n,
    input regAddrT awaddr,
    input logic    awvalid,
    input logic    awready,
    input busT     wdata,
    input logic    wvalid,
    input logic    wready,
    input logic    bvalid,
    input logic    bready,
    input regAddrT araddr,
    input logic    arvalid,
    input logic    arready,
    input busT     rdata,
    input logic    rvalid,
    input logic    rready,
    input logic    busy,
    input logic    done
);

    // valid and payload held until the transfer
    awHold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW channel changed before its transfer");

    wHold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("W channel changed before its transfer");

    arHold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR channel changed before its transfer");

    bHold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rHold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("R channel changed before rready");

    busyDone: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
        else $error("busy and done high together");

    resetQuiet: assert property (@(posedge clk) $rose(rst_n) |-> !bvalid && !rvalid)
        else $error("bvalid or rvalid high right after reset");

endmodule

bind scMulTop scMulTop_assert assert0 (.*);
